//--- common/issue_pkg.sv
// shared definitions of the operand-read and issue stage
//   widths and counts of the integer datapath
//   functional unit and operation enums
//   issue entry, scoreboard reply and commit port structs
//   execute bundle and unit strobes
`default_nettype none

package issue_pkg;

    // --------------------
    // widths and counts
    // --------------------
    localparam int unsigned XLEN            = 64;
    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned NR_READ_PORTS   = 2;
    localparam int unsigned REG_ADDR_BITS   = $clog2(NR_REGS);
    localparam int unsigned TRANS_ID_BITS   = 3;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // --------------------
    // enums
    // --------------------
    // NONE must stay at zero, the reset value of the bundle relies on it
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        MULT      = 3'd3,
        LOAD      = 3'd4,
        STORE     = 3'd5,
        CSR       = 3'd6
    } fu_t;

    // carried through to the unit, never decoded here
    typedef enum logic [6:0] {
        ADD, SUB, ADDW, SUBW, XORL, ORL, ANDL,
        SRA, SRL, SLL, SRLW, SLLW, SRAW,
        LTS, LTU, GES, GEU, EQ, NE,
        JALR, BRANCH,
        LD, SD, LW, SW, LH, SH, LB, SB, LWU, LHU, LBU,
        MUL, MULH, MULHU, MULHSU, MULW,
        DIV, DIVU, DIVW, DIVUW, REM, REMU, REMW, REMUW,
        CSR_WRITE, CSR_READ, CSR_SET, CSR_CLEAR
    } fu_op_t;

    // unit that will write each register, NONE when no write is pending
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // --------------------
    // structs
    // --------------------
    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        // immediate, or the store / branch offset
        word_t     result;
        trans_id_t trans_id;
        fu_t       fu;
        fu_op_t    op;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        // exception already raised upstream
        logic      ex_valid;
    } issue_entry_t;

    typedef struct packed {
        word_t word;
        logic  valid;
    } operand_rsp_t;

    typedef struct packed {
        reg_addr_t waddr;
        word_t     wdata;
        logic      we;
    } commit_port_t;

    typedef struct packed {
        word_t     operand_a;
        word_t     operand_b;
        word_t     imm;
        fu_t       fu;
        fu_op_t    op;
        trans_id_t trans_id;
    } fu_data_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

endpackage

`default_nettype wire

//--- regfile/int_regfile.sv
// integer register file
//   two combinational read ports
//   commit write ports, higher port index wins on a collision
//   x0 hardwired to zero
`default_nettype none

module int_regfile (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_ni,
    input  wire issue_pkg::reg_addr_t [issue_pkg::NR_READ_PORTS-1:0]  raddr_i,
    output issue_pkg::word_t [issue_pkg::NR_READ_PORTS-1:0]           rdata_o,
    input  wire issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i
);
    import issue_pkg::*;

    // architectural state, x0 has no storage
    word_t [NR_REGS-1:1] mem_q;

    // --------------------
    // write
    // --------------------
    // ports are visited in ascending order so the last assignment,
    // from the highest port, is the one that sticks
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '0;
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // --------------------
    // read
    // --------------------
    // pre-edge contents, a write in the same cycle is not bypassed
    always_comb begin
        for (int unsigned r = 0; r < NR_READ_PORTS; r++) begin
            if (raddr_i[r] == '0) begin
                // zero register
                rdata_o[r] = '0;
            end else begin
                rdata_o[r] = mem_q[raddr_i[r]];
            end
        end
    end

endmodule

`default_nettype wire

//--- issue/operand_hazard.sv
// read-after-write hazard check for the two sources
//   clobber lookup per source register
//   forward decision when the scoreboard holds the value
//   stall when a pending value cannot be forwarded
`default_nettype none

module operand_hazard (
    input  wire issue_pkg::issue_entry_t entry_i,
    input  wire issue_pkg::clobber_t     clobber_i,
    input  wire issue_pkg::operand_rsp_t rs1_rsp_i,
    input  wire issue_pkg::operand_rsp_t rs2_rsp_i,
    output logic                         fwd_rs1_o,
    output logic                         fwd_rs2_o,
    output logic                         stall_o
);
    import issue_pkg::*;

    // unit that will write each source
    fu_t  rs1_writer;
    fu_t  rs2_writer;
    // a write to the source is still outstanding
    logic rs1_pending;
    logic rs2_pending;
    // the pending value cannot be taken from the scoreboard
    logic rs1_blocked;
    logic rs2_blocked;

    // --------------------
    // clobber lookup
    // --------------------
    assign rs1_writer = clobber_i[entry_i.rs1];
    assign rs2_writer = clobber_i[entry_i.rs2];

    // with zimm the rs1 field is an immediate, not a register
    assign rs1_pending = !entry_i.use_zimm && (rs1_writer != NONE);
    assign rs2_pending = (rs2_writer != NONE);

    // --------------------
    // forward or stall
    // --------------------
    // csr results only ever reach the core through the register file
    always_comb begin
        fwd_rs1_o   = 1'b0;
        rs1_blocked = 1'b0;
        if (rs1_pending) begin
            if (rs1_rsp_i.valid && (rs1_writer != CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                rs1_blocked = 1'b1;
            end
        end
    end

    always_comb begin
        fwd_rs2_o   = 1'b0;
        rs2_blocked = 1'b0;
        if (rs2_pending) begin
            if (rs2_rsp_i.valid && (rs2_writer != CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                rs2_blocked = 1'b1;
            end
        end
    end

    // either source missing holds the entry
    assign stall_o = rs1_blocked || rs2_blocked;

endmodule

`default_nettype wire

//--- issue/operand_select.sv
// operand multiplexing for the execute bundle
//   operand a from register, forward, pc or zimm
//   operand b from register, forward or immediate
`default_nettype none

module operand_select (
    input  wire issue_pkg::issue_entry_t                         entry_i,
    input  wire issue_pkg::word_t [issue_pkg::NR_READ_PORTS-1:0] rdata_i,
    input  wire issue_pkg::operand_rsp_t                         rs1_rsp_i,
    input  wire issue_pkg::operand_rsp_t                         rs2_rsp_i,
    input  wire logic                                            fwd_rs1_i,
    input  wire logic                                            fwd_rs2_i,
    output issue_pkg::fu_data_t                                  ex_data_o
);
    import issue_pkg::*;

    // stores and branches keep operand b as a register,
    // their immediate travels in imm
    logic imm_to_b;

    assign imm_to_b = entry_i.use_imm && (entry_i.fu != STORE) && (entry_i.fu != CTRL_FLOW);

    always_comb begin
        // register file by default
        ex_data_o.operand_a = rdata_i[0];
        ex_data_o.operand_b = rdata_i[1];

        // scoreboard value beats the stale register
        if (fwd_rs1_i) begin
            ex_data_o.operand_a = rs1_rsp_i.word;
        end
        if (fwd_rs2_i) begin
            ex_data_o.operand_b = rs2_rsp_i.word;
        end

        // pc relative operations, auipc and jumps
        if (entry_i.use_pc) begin
            ex_data_o.operand_a = entry_i.pc;
        end
        // csr immediate forms, the 5 bit field zero extended
        if (entry_i.use_zimm) begin
            ex_data_o.operand_a = {{(XLEN-REG_ADDR_BITS){1'b0}}, entry_i.rs1};
        end

        if (imm_to_b) begin
            ex_data_o.operand_b = entry_i.result;
        end

        // pass-through fields
        ex_data_o.imm      = entry_i.result;
        ex_data_o.fu       = entry_i.fu;
        ex_data_o.op       = entry_i.op;
        ex_data_o.trans_id = entry_i.trans_id;
    end

endmodule

`default_nettype wire

//--- issue/issue_ctrl.sv
// issue control
//   busy selection per unit group
//   write-after-write check against the clobber list and commit ports
//   acknowledge and the strobes for the next cycle
`default_nettype none

module issue_ctrl (
    input  wire issue_pkg::issue_entry_t                              entry_i,
    input  wire logic                                                 issue_valid_i,
    input  wire issue_pkg::clobber_t                                  clobber_i,
    input  wire issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    input  wire logic                                                 flu_ready_i,
    input  wire logic                                                 lsu_ready_i,
    input  wire logic                                                 stall_i,
    input  wire logic                                                 flush_i,
    input  wire logic                                                 mult_issued_i,
    output logic                                                      issue_ack_o,
    output issue_pkg::unit_valid_t                                    valid_d_o
);
    import issue_pkg::*;

    logic fu_busy;
    logic rd_free;

    // --------------------
    // unit busy
    // --------------------
    always_comb begin
        case (entry_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = !flu_ready_i;
            LOAD, STORE:               fu_busy = !lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // waw check
    // --------------------
    // rd is free if nobody claims it, or its writer commits right now
    always_comb begin
        rd_free = (clobber_i[entry_i.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == entry_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    // --------------------
    // acknowledge
    // --------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall_i && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and no-unit entries need no operands and no unit
            if (entry_i.ex_valid || (entry_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // multiplier result shares the fixed latency writeback with the
        // other units, so only a multiply may follow a multiply
        if (mult_issued_i && (entry_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // --------------------
    // next-cycle strobes
    // --------------------
    always_comb begin
        valid_d_o = '0;
        if (issue_ack_o && !entry_i.ex_valid && !flush_i) begin
            case (entry_i.fu)
                ALU:         valid_d_o.alu    = 1'b1;
                CTRL_FLOW:   valid_d_o.branch = 1'b1;
                MULT:        valid_d_o.mult   = 1'b1;
                LOAD, STORE: valid_d_o.lsu    = 1'b1;
                CSR:         valid_d_o.csr    = 1'b1;
                default:     valid_d_o        = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- issue/issue_ex_regs.sv
// issue to execute pipeline register
//   execute bundle, loaded every cycle
//   unit strobes, one cycle wide
//   registered mult strobe fed back for contention tracking
`default_nettype none

module issue_ex_regs (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire issue_pkg::fu_data_t    ex_data_i,
    input  wire issue_pkg::unit_valid_t valid_d_i,
    output issue_pkg::fu_data_t         fu_data_o,
    output issue_pkg::unit_valid_t      unit_valid_o,
    output logic                        mult_issued_o
);
    import issue_pkg::*;

    // --------------------
    // bundle
    // --------------------
    // cleared to an idle bundle with no unit selected
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{
                operand_a: '0,
                operand_b: '0,
                imm:       '0,
                fu:        NONE,
                op:        ADD,
                trans_id:  '0
            };
        end else begin
            fu_data_o <= ex_data_i;
        end
    end

    // --------------------
    // strobes
    // --------------------
    // a strobe lasts one cycle unless the next entry is accepted
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            unit_valid_o <= '0;
        end else begin
            unit_valid_o <= valid_d_i;
        end
    end

    // multiply in flight on the execute side this cycle
    assign mult_issued_o = unit_valid_o.mult;

endmodule

`default_nettype wire

//--- verilog/issue_read_operands.sv
// operand-read and issue stage, top level
//   register file, hazard check, operand select
//   issue control and the execute pipeline register
`default_nettype none

module issue_read_operands (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_ni,
    input  wire logic                                                 flush_i,
    // decoded entry from the scoreboard
    input  wire issue_pkg::issue_entry_t                              issue_entry_i,
    input  wire logic                                                 issue_valid_i,
    output logic                                                      issue_ack_o,
    // source lookup in the scoreboard
    output issue_pkg::reg_addr_t                                      rs1_o,
    output issue_pkg::reg_addr_t                                      rs2_o,
    input  wire issue_pkg::operand_rsp_t                              rs1_rsp_i,
    input  wire issue_pkg::operand_rsp_t                              rs2_rsp_i,
    input  wire issue_pkg::clobber_t                                  clobber_i,
    // register writes from commit
    input  wire issue_pkg::commit_port_t [issue_pkg::NR_COMMIT_PORTS-1:0] commit_i,
    // unit group readiness
    input  wire logic                                                 flu_ready_i,
    input  wire logic                                                 lsu_ready_i,
    // to the execute stage
    output issue_pkg::fu_data_t                                       fu_data_o,
    output issue_pkg::unit_valid_t                                    unit_valid_o
);
    import issue_pkg::*;

    reg_addr_t [NR_READ_PORTS-1:0] raddr;
    word_t [NR_READ_PORTS-1:0]     rdata;
    logic                          fwd_rs1;
    logic                          fwd_rs2;
    logic                          stall;
    fu_data_t                      ex_data;
    unit_valid_t                   valid_d;
    logic                          mult_issued;

    // sources go straight to the scoreboard and the register file
    assign rs1_o = issue_entry_i.rs1;
    assign rs2_o = issue_entry_i.rs2;
    assign raddr = {issue_entry_i.rs2, issue_entry_i.rs1};

    int_regfile int_regfile_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .raddr_i  (raddr),
        .rdata_o  (rdata),
        .commit_i (commit_i)
    );

    operand_hazard operand_hazard_i (
        .entry_i   (issue_entry_i),
        .clobber_i (clobber_i),
        .rs1_rsp_i (rs1_rsp_i),
        .rs2_rsp_i (rs2_rsp_i),
        .fwd_rs1_o (fwd_rs1),
        .fwd_rs2_o (fwd_rs2),
        .stall_o   (stall)
    );

    operand_select operand_select_i (
        .entry_i   (issue_entry_i),
        .rdata_i   (rdata),
        .rs1_rsp_i (rs1_rsp_i),
        .rs2_rsp_i (rs2_rsp_i),
        .fwd_rs1_i (fwd_rs1),
        .fwd_rs2_i (fwd_rs2),
        .ex_data_o (ex_data)
    );

    issue_ctrl issue_ctrl_i (
        .entry_i       (issue_entry_i),
        .issue_valid_i (issue_valid_i),
        .clobber_i     (clobber_i),
        .commit_i      (commit_i),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .stall_i       (stall),
        .flush_i       (flush_i),
        .mult_issued_i (mult_issued),
        .issue_ack_o   (issue_ack_o),
        .valid_d_o     (valid_d)
    );

    issue_ex_regs issue_ex_regs_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ex_data_i     (ex_data),
        .valid_d_i     (valid_d),
        .fu_data_o     (fu_data_o),
        .unit_valid_o  (unit_valid_o),
        .mult_issued_o (mult_issued)
    );

endmodule

`default_nettype wire

//--- dv/tb_issue_read_operands.sv
// testbench of the operand-read and issue stage
//   shadow register file fed from the commit ports
//   reference prediction of acknowledge, strobes and execute bundle
//   directed register file and multiply sequences, then random traffic
//   watchdog bounded by the number of tests
`default_nettype none

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned CLK_PERIOD  = 20;
    localparam int unsigned DRIVE_DELAY = 2;
    localparam int unsigned N_DIRECTED  = 48;
    localparam int unsigned N_RANDOM    = 400;
    localparam int unsigned N_TESTS     = N_DIRECTED + N_RANDOM;

    logic                               clk_i;
    logic                               rst_ni;
    logic                               flush;
    issue_entry_t                       entry;
    logic                               issue_valid;
    logic                               issue_ack;
    reg_addr_t                          rs1;
    reg_addr_t                          rs2;
    operand_rsp_t                       rs1_rsp;
    operand_rsp_t                       rs2_rsp;
    clobber_t                           clobber;
    commit_port_t [NR_COMMIT_PORTS-1:0] commit;
    logic                               flu_ready;
    logic                               lsu_ready;
    fu_data_t                           fu_data;
    unit_valid_t                        unit_valid;

    // reference state
    word_t        shadow_regs [NR_REGS];
    unit_valid_t  exp_strobe   = '0;
    fu_data_t     exp_data     = '0;
    logic         was_accepted = 1'b0;
    logic [15:0]  lfsr_state;
    int unsigned  checks       = 0;
    int unsigned  errors       = 0;
    int unsigned  accepted     = 0;

    issue_read_operands issue_read_operands_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush),
        .issue_entry_i (entry),
        .issue_valid_i (issue_valid),
        .issue_ack_o   (issue_ack),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_rsp_i     (rs1_rsp),
        .rs2_rsp_i     (rs2_rsp),
        .clobber_i     (clobber),
        .commit_i      (commit),
        .flu_ready_i   (flu_ready),
        .lsu_ready_i   (lsu_ready),
        .fu_data_o     (fu_data),
        .unit_valid_o  (unit_valid)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // --------------------
    // helpers
    // --------------------
    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int unsigned n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v          = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic fu_t rand_unit();
        return fu_t'(3'(rand_bits(3) % 7));
    endfunction

    task automatic check_that(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    // --------------------
    // shadow register file
    // --------------------
    // later ports overwrite earlier ones, x0 never changes
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < NR_REGS; r++) begin
                shadow_regs[r] = '0;
            end
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit[p].we && (commit[p].waddr != 0)) begin
                    shadow_regs[commit[p].waddr] = commit[p].wdata;
                end
            end
        end
    end

    // --------------------
    // checker
    // --------------------
    // registered outputs against last cycle's prediction
    task automatic check_registered();
        check_that(unit_valid == exp_strobe,
            $sformatf("strobes %b, expected %b", unit_valid, exp_strobe));
        check_that($countones(unit_valid) <= 1, "more than one unit strobe raised");
        check_that(fu_data == exp_data,
            $sformatf("execute bundle %h, expected %h", fu_data, exp_data));
    endtask

    // acknowledge now, strobes and bundle for the next cycle
    task automatic predict_cycle();
        fu_t         rs1_writer;
        fu_t         rs2_writer;
        logic        rs1_pend;
        logic        rs2_pend;
        logic        rs1_fwd;
        logic        rs2_fwd;
        logic        blocked;
        logic        busy;
        logic        rd_free;
        logic        ack;
        fu_data_t    data;
        unit_valid_t strobe;

        rs1_writer = clobber[entry.rs1];
        rs2_writer = clobber[entry.rs2];
        // zimm turns rs1 into an immediate field
        rs1_pend   = !entry.use_zimm && (rs1_writer != NONE);
        rs2_pend   = (rs2_writer != NONE);
        rs1_fwd    = rs1_pend && rs1_rsp.valid && (rs1_writer != CSR);
        rs2_fwd    = rs2_pend && rs2_rsp.valid && (rs2_writer != CSR);
        blocked    = (rs1_pend && !rs1_fwd) || (rs2_pend && !rs2_fwd);

        busy = (entry.fu inside {LOAD, STORE}) ? !lsu_ready : ((entry.fu != NONE) && !flu_ready);

        rd_free = (clobber[entry.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            rd_free = rd_free || (commit[p].we && (commit[p].waddr == entry.rd));
        end

        ack = issue_valid && ((!blocked && !busy && rd_free) || entry.ex_valid ||
              (entry.fu == NONE));
        // a multiply on the execute side admits only another multiply
        if (exp_strobe.mult && (entry.fu != MULT)) begin
            ack = 1'b0;
        end

        data.operand_a = rs1_fwd ? rs1_rsp.word : shadow_regs[entry.rs1];
        if (entry.use_pc) begin
            data.operand_a = entry.pc;
        end
        if (entry.use_zimm) begin
            data.operand_a = word_t'(entry.rs1);
        end
        data.operand_b = rs2_fwd ? rs2_rsp.word : shadow_regs[entry.rs2];
        if (entry.use_imm && !(entry.fu inside {STORE, CTRL_FLOW})) begin
            data.operand_b = entry.result;
        end
        data.imm      = entry.result;
        data.fu       = entry.fu;
        data.op       = entry.op;
        data.trans_id = entry.trans_id;

        strobe = '0;
        if (ack && !entry.ex_valid && !flush) begin
            strobe.alu    = (entry.fu == ALU);
            strobe.branch = (entry.fu == CTRL_FLOW);
            strobe.lsu    = (entry.fu inside {LOAD, STORE});
            strobe.mult   = (entry.fu == MULT);
            strobe.csr    = (entry.fu == CSR);
        end

        check_that(issue_ack == ack,
            $sformatf("ack %0b, expected %0b, fu %0d", issue_ack, ack, entry.fu));
        check_that((rs1 == entry.rs1) && (rs2 == entry.rs2), "source indices not passed on");

        if (ack) begin
            accepted++;
        end
        exp_strobe = strobe;
        exp_data   = data;
    endtask

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            exp_strobe = '0;
            exp_data   = '0;
        end else begin
            check_registered();
            predict_cycle();
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic next_cycle();
        @(negedge clk_i);
        was_accepted = issue_valid && issue_ack;
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic idle_inputs();
        flush       = 1'b0;
        issue_valid = 1'b0;
        entry       = '0;
        rs1_rsp     = '0;
        rs2_rsp     = '0;
        clobber     = '0;
        commit      = '0;
        flu_ready   = 1'b1;
        lsu_ready   = 1'b1;
    endtask

    // plain entry for one unit, no flags and no exception
    task automatic present(input fu_t fu);
        entry          = '0;
        entry.pc       = rand_bits(64);
        entry.rs1      = reg_addr_t'(rand_bits(5));
        entry.rs2      = reg_addr_t'(rand_bits(5));
        entry.rd       = reg_addr_t'(rand_bits(5));
        entry.result   = rand_bits(64);
        entry.trans_id = trans_id_t'(rand_bits(3));
        entry.fu       = fu;
        issue_valid    = 1'b1;
    endtask

    task automatic regfile_round_trip();
        idle_inputs();
        for (int unsigned n = 0; n < 16; n++) begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                commit[p].we    = 1'b1;
                commit[p].waddr = reg_addr_t'(rand_bits(5));
                commit[p].wdata = rand_bits(64);
            end
            // same target on both ports now and then
            if ((n % 4) == 0) begin
                commit[1].waddr = commit[0].waddr;
            end
            next_cycle();
        end
        commit = '0;
        for (int unsigned n = 0; n < 16; n++) begin
            present(ALU);
            if (n == 0) begin
                entry.rs1 = '0;
                entry.rs2 = '0;
            end
            next_cycle();
        end
        issue_valid = 1'b0;
        next_cycle();
    endtask

    task automatic multiply_contention();
        idle_inputs();
        present(MULT);
        next_cycle();
        // refused while the multiply strobe is up, then taken
        present(ALU);
        next_cycle();
        next_cycle();
        present(MULT);
        next_cycle();
        present(MULT);
        next_cycle();
        present(CSR);
        next_cycle();
        next_cycle();
        issue_valid = 1'b0;
        next_cycle();
    endtask

    task automatic random_entry();
        present(rand_unit());
        entry.op       = fu_op_t'(7'(rand_bits(6) % 49));
        entry.use_imm  = (rand_bits(2) == 0);
        entry.use_pc   = (rand_bits(2) == 0);
        entry.use_zimm = (rand_bits(2) == 0);
        entry.ex_valid = (rand_bits(3) == 0);
        issue_valid    = (rand_bits(3) != 0);
    endtask

    // scoreboard, commit and unit state around the entry
    task automatic random_env();
        clobber = '0;
        if (rand_bits(2) == 0) begin
            clobber[entry.rs1] = rand_unit();
        end
        if (rand_bits(2) == 0) begin
            clobber[entry.rs2] = rand_unit();
        end
        if (rand_bits(2) == 0) begin
            clobber[entry.rd] = rand_unit();
        end
        clobber[reg_addr_t'(rand_bits(5))] = rand_unit();
        rs1_rsp.valid = (rand_bits(2) != 0);
        rs1_rsp.word  = rand_bits(64);
        rs2_rsp.valid = (rand_bits(2) != 0);
        rs2_rsp.word  = rand_bits(64);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            commit[p].we    = rand_bits(1) == 1;
            commit[p].waddr = reg_addr_t'(rand_bits(5));
            commit[p].wdata = rand_bits(64);
        end
        // writer of rd retiring in the same cycle
        if (rand_bits(2) == 0) begin
            commit[1].we    = 1'b1;
            commit[1].waddr = entry.rd;
        end
        flu_ready = (rand_bits(3) != 0);
        lsu_ready = (rand_bits(3) != 0);
        flush     = (rand_bits(3) == 0);
    endtask

    task automatic random_traffic();
        for (int unsigned n = 0; n < N_RANDOM; n++) begin
            // a refused entry stays on the inputs
            if (!(issue_valid && !was_accepted)) begin
                random_entry();
            end
            random_env();
            next_cycle();
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        lfsr_state = 16'd47292;
        rst_ni     = 1'b0;
        idle_inputs();
        repeat (5) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;

        regfile_round_trip();
        multiply_contention();
        random_traffic();
        idle_inputs();
        next_cycle();
        next_cycle();

        $display("checks %0d, errors %0d, accepted entries %0d", checks, errors, accepted);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(N_TESTS * 40 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", N_TESTS * 40);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/issue_pkg.sv
regfile/int_regfile.sv
issue/operand_hazard.sv
issue/operand_select.sv
issue/issue_ctrl.sv
issue/issue_ex_regs.sv
verilog/issue_read_operands.sv
dv/tb_issue_read_operands.sv

//--- run.sh
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_issue_read_operands -f compile.f -o sim_issue &&
sim_out="$(./obj_dir/sim_issue)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qx 'TEST PASS' ||
{
    echo "simulation failed"
    exit 1
}
